// ==== filelist.f ====
+incdir+src
src/ch4_pkg.sv
src/ch4_regs.sv
src/ch4_length.sv
src/ch4_envelope.sv
src/ch4_noise.sv
src/ch4_top.sv
test/ch4_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module ch4_tb -f filelist.f
	-./obj_dir/Vch4_tb > sim.log 2>&1
	@cat sim.log
	@if grep -q "TB FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" sim.log; then echo "simulation ended without a result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

// ==== test/ch4_tb.sv ====
`include "ch4_settings.svh"

module ch4_tb
	import ch4_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 20000; // tests need a little over 4000 cycles
	localparam int LW = `CH4_LFSR_W;
	localparam int DIV_TABLE [8] = '{8, 16, 32, 48, 64, 80, 96, 112};
	localparam logic [2:0] LEN = 3'b001; // tick selects for run_ticks
	localparam logic [2:0] ENV = 3'b010;
	localparam logic [2:0] DIV = 3'b100;

	logic                   clk;
	logic                   reset;
	ch4_bus_t               bus;
	logic                   len_tick;
	logic                   env_tick;
	logic                   div_tick;
	logic [`CH4_DATA_W-1:0] rdata;
	logic [3:0]             sample;
	logic                   active;

	int seed;
	int cycle_count = 0;
	int err_rdata   = 0;
	int err_sample  = 0;
	int err_active  = 0;

	// reference model state, moves on the same edges as the DUT
	logic [7:0]    m_nr42;
	logic [7:0]    m_nr43;
	logic          m_len_en;
	logic [5:0]    m_len_data;
	logic          m_len_load;
	logic          m_trig;
	logic          m_active;
	logic [3:0]    m_vol;
	logic [LW-1:0] m_lfsr;
	int            m_left;
	int            m_timer;
	int            m_div;
	logic          m_dac;

	assign m_dac = (m_nr42[7:3] != 5'd0);

	ch4_top ch4_top_inst (
		.clk      (clk),
		.reset    (reset),
		.bus      (bus),
		.len_tick (len_tick),
		.env_tick (env_tick),
		.div_tick (div_tick),
		.rdata    (rdata),
		.sample   (sample),
		.active   (active)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
		$display("TB FAILED");
		$finish;
	end

	function automatic logic [7:0] exp_rdata(input ch4_reg_e addr, input logic [7:0] nr42,
			input logic [7:0] nr43, input logic len_en);
		case (addr)
			NR42: return nr42;
			NR43: return nr43;
			NR44: return {1'b1, len_en, 6'h3f}; // bit 6 only
			default: return 8'hff; // ff20 is write only
		endcase
	endfunction

	function automatic logic [LW-1:0] exp_lfsr_step(input logic [LW-1:0] s, input logic short_mode);
		logic          fb;
		logic [LW-1:0] n;
		fb = s[0] ^ s[1];
		n  = {fb, s[LW-1:1]}; // shifts toward bit 0
		if (short_mode) begin
			n[`CH4_LFSR_SHORT_TAP] = fb;
		end
		return n;
	endfunction

	function automatic int exp_period(input logic [2:0] code, input logic [3:0] shift);
		return DIV_TABLE[code] << shift;
	endfunction

	function automatic logic [3:0] exp_volume_step(input logic [3:0] vol, input logic up);
		if (up) begin
			return (vol == 4'd15) ? vol : vol + 4'd1;
		end
		return (vol == 4'd0) ? vol : vol - 4'd1;
	endfunction

	task automatic check_rdata(input logic [`CH4_DATA_W-1:0] got, exp, input string what);
		if (got !== exp) begin
			err_rdata++;
			$display("Fail %0t: %s rdata %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_sample(input logic [3:0] got, exp, input string what);
		if (got !== exp) begin
			err_sample++;
			$display("Fail %0t: %s sample %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_active(input logic got, exp, input string what);
		if (got !== exp) begin
			err_active++;
			$display("Fail %0t: %s active %b, expected %b", $time, what, got, exp);
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			{m_nr42, m_nr43, m_len_en, m_len_load, m_trig, m_active} <= '0;
			m_len_data <= '0;
			m_vol      <= '0;
			m_lfsr     <= '1;
			m_left     <= 0;
			m_timer    <= 0;
			m_div      <= 0;
		end else begin
			m_len_load <= bus.wr && (bus.addr == NR41);
			m_trig     <= bus.wr && (bus.addr == NR44) && bus.wdata[7];
			if (bus.wr) begin
				case (bus.addr)
					NR41: m_len_data <= bus.wdata[5:0];
					NR42: m_nr42 <= bus.wdata;
					NR43: m_nr43 <= bus.wdata;
					NR44: m_len_en <= bus.wdata[6];
				endcase
			end
			if (m_len_load) begin
				m_left <= 64 - int'(m_len_data);
			end else if (m_trig && m_left == 0) begin
				m_left <= 64;
			end else if (len_tick && m_len_en && m_left != 0) begin
				m_left <= m_left - 1;
			end
			if (!m_dac) begin
				m_active <= 1'b0;
			end else if (m_trig) begin
				m_active <= 1'b1;
			end else if (len_tick && m_len_en && m_left == 1) begin
				m_active <= 1'b0; // expiry
			end
			if (m_trig) begin
				m_vol   <= m_nr42[7:4];
				m_timer <= m_nr42[2:0];
			end else if (env_tick && m_nr42[2:0] != 3'd0) begin
				if (m_timer <= 1) begin
					m_timer <= m_nr42[2:0];
					m_vol   <= exp_volume_step(m_vol, m_nr42[3]);
				end else begin
					m_timer <= m_timer - 1;
				end
			end
			if (m_trig) begin
				m_lfsr <= '1;
				m_div  <= exp_period(m_nr43[2:0], m_nr43[7:4]);
			end else if (div_tick) begin
				if (m_div <= 1) begin
					m_lfsr <= exp_lfsr_step(m_lfsr, m_nr43[3]);
					m_div  <= exp_period(m_nr43[2:0], m_nr43[7:4]);
				end else begin
					m_div <= m_div - 1;
				end
			end
		end
	end

	// outputs are settled by the falling edge
	always @(negedge clk) begin
		if (!reset) begin
			check_sample(sample, (m_active && !m_lfsr[0]) ? m_vol : 4'd0, "model");
			check_active(active, m_active, "model");
			check_rdata(rdata, bus.rd ? exp_rdata(bus.addr, m_nr42, m_nr43, m_len_en) : 8'hff,
				"model");
		end
	end

	task automatic bus_cycle(input logic wr, input ch4_reg_e addr, input logic [7:0] data);
		@(posedge clk);
		bus <= '{wr: wr, rd: !wr, addr: addr, wdata: data};
		@(posedge clk);
		bus <= '{wr: 1'b0, rd: 1'b0, addr: NR41, wdata: 8'h00};
	endtask

	// one tick per cycle for n cycles
	task automatic run_ticks(input logic [2:0] sel, input int n);
		@(posedge clk);
		{div_tick, env_tick, len_tick} <= sel;
		repeat (n) @(posedge clk);
		{div_tick, env_tick, len_tick} <= 3'b000;
	endtask

	task automatic random_reg_access();
		for (int round = 0; round < 8; round++) begin
			for (int a = 0; a < 4; a++) begin
				bus_cycle(1'b1, ch4_reg_e'(a), 8'($random(seed)));
			end
			for (int a = 0; a < 4; a++) begin
				bus_cycle(1'b0, ch4_reg_e'(a), 8'h00);
			end
		end
	endtask

	task automatic length_expiry();
		logic [5:0] len;
		bus_cycle(1'b1, NR42, 8'hf0); // volume 15, frozen
		for (int i = 0; i < 3; i++) begin
			len = 6'($random(seed));
			bus_cycle(1'b1, NR41, {2'b00, len});
			bus_cycle(1'b1, NR44, 8'hc0); // trigger with length enabled
			run_ticks(LEN, 63 - int'(len));
			@(negedge clk);
			check_active(active, 1'b1, "before last length tick");
			run_ticks(LEN, 1);
			@(negedge clk);
			check_active(active, 1'b0, "after last length tick");
		end
		bus_cycle(1'b1, NR41, 8'd60);
		bus_cycle(1'b1, NR44, 8'h80); // length disabled
		run_ticks(LEN, 10);
		@(negedge clk);
		check_active(active, 1'b1, "length disabled");
	endtask

	task automatic envelope_ramp();
		logic [LW-1:0] s;
		int            shifts;
		logic          up;
		logic [2:0]    period;
		logic [3:0]    init;
		s      = '1;
		shifts = 0;
		while (s[0]) begin
			s = exp_lfsr_step(s, 1'b0);
			shifts++;
		end
		for (int mode = 0; mode < 4; mode++) begin
			up     = mode[0];
			period = mode[1] ? 3'd0 : 3'd3;
			init   = up ? 4'd13 : 4'd2; // two steps from the rail
			bus_cycle(1'b1, NR43, 8'h00); // divisor 8, long lfsr
			bus_cycle(1'b1, NR42, {init, up, period});
			bus_cycle(1'b1, NR44, 8'h80);
			run_ticks(DIV, shifts * exp_period(3'd0, 4'd0)); // park on noise high
			run_ticks(ENV, 40);
			@(negedge clk);
			check_sample(sample, (period == 3'd0) ? init : (up ? 4'd15 : 4'd0), "envelope");
		end
	endtask

	task automatic noise_sequence();
		logic [7:0]    cfg [4];
		logic [3:0]    vol;
		logic [LW-1:0] s;
		cfg = '{8'h00, 8'h19, 8'h0b, 8'h12}; // periods 8, 32, 48, 64
		for (int i = 0; i < 4; i++) begin
			vol = 4'(8 + ($random(seed) & 7));
			s   = '1;
			bus_cycle(1'b1, NR42, {vol, 4'h0});
			bus_cycle(1'b1, NR43, cfg[i]);
			bus_cycle(1'b1, NR44, 8'h80);
			run_ticks(DIV, 20 * exp_period(cfg[i][2:0], cfg[i][7:4]));
			repeat (20)
				s = exp_lfsr_step(s, cfg[i][3]);
			@(negedge clk);
			check_sample(sample, s[0] ? 4'd0 : vol, "noise after 20 shifts");
		end
	endtask

	task automatic dac_power_off();
		bus_cycle(1'b1, NR42, 8'hf0);
		bus_cycle(1'b1, NR44, 8'h80);
		@(posedge clk);
		@(negedge clk);
		check_active(active, 1'b1, "trigger with dac on");
		bus_cycle(1'b1, NR42, 8'h07); // volume 0, down
		@(posedge clk);
		@(negedge clk);
		check_active(active, 1'b0, "dac switched off");
		bus_cycle(1'b1, NR44, 8'hc0);
		repeat (3) @(posedge clk);
		@(negedge clk);
		check_active(active, 1'b0, "trigger with dac off");
	endtask

	initial begin
		seed     = 56;
		reset    = 1'b1;
		bus      = '0;
		len_tick = 1'b0;
		env_tick = 1'b0;
		div_tick = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		random_reg_access();
		length_expiry();
		envelope_ramp();
		noise_sequence();
		dac_power_off();
		repeat (4) @(posedge clk);
		$display("errors: rdata %0d, sample %0d, active %0d", err_rdata, err_sample, err_active);
		if (err_rdata + err_sample + err_active == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== src/ch4_top.sv ====
`include "ch4_settings.svh"

module ch4_top
	import ch4_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	input  ch4_bus_t               bus,
	input  logic                   len_tick,
	input  logic                   env_tick,
	input  logic                   div_tick,
	output logic [`CH4_DATA_W-1:0] rdata,
	output logic [3:0]             sample,
	output logic                   active
);

	ch4_env_cfg_t          env_cfg;
	ch4_poly_cfg_t         poly_cfg;
	logic                  len_en;
	logic                  len_load;
	logic [`CH4_LEN_W-1:0] len_data;
	logic                  trigger;
	logic                  dac_on;
	logic [3:0]            volume;
	logic                  noise_bit;

	ch4_regs ch4_regs_inst (
		.clk      (clk),
		.reset    (reset),
		.bus      (bus),
		.rdata    (rdata),
		.env_cfg  (env_cfg),
		.poly_cfg (poly_cfg),
		.len_en   (len_en),
		.len_load (len_load),
		.len_data (len_data),
		.trigger  (trigger),
		.dac_on   (dac_on)
	);

	ch4_length ch4_length_inst (
		.clk      (clk),
		.reset    (reset),
		.len_tick (len_tick),
		.len_en   (len_en),
		.len_load (len_load),
		.len_data (len_data),
		.trigger  (trigger),
		.dac_on   (dac_on),
		.active   (active)
	);

	ch4_envelope ch4_envelope_inst (
		.clk      (clk),
		.reset    (reset),
		.env_tick (env_tick),
		.trigger  (trigger),
		.env_cfg  (env_cfg),
		.volume   (volume)
	);

	ch4_noise ch4_noise_inst (
		.clk       (clk),
		.reset     (reset),
		.div_tick  (div_tick),
		.trigger   (trigger),
		.poly_cfg  (poly_cfg),
		.noise_bit (noise_bit)
	);

	// silent unless the channel runs and the noise bit is high
	assign sample = (active && noise_bit) ? volume : 4'd0;

endmodule

// ==== src/ch4_noise.sv ====
`include "ch4_settings.svh"

module ch4_noise
	import ch4_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          div_tick,
	input  logic          trigger,
	input  ch4_poly_cfg_t poly_cfg,
	output logic          noise_bit
);

	localparam int LW    = `CH4_LFSR_W;
	localparam int DIV_W = 7 + 15; // largest base 112, largest shift 15

	logic [LW-1:0]    lfsr;
	logic [LW-1:0]    lfsr_next;
	logic             feedback;
	logic [DIV_W-1:0] div_cnt;
	logic [DIV_W-1:0] reload;

	// divisor table 8,16,32..112 then shifted
	function automatic logic [DIV_W-1:0] div_period(
		input logic [2:0] code,
		input logic [3:0] shift
	);
		logic [6:0] base;
		base = (code == 3'd0) ? 7'd8 : {code, 4'b0000};
		return DIV_W'(base) << shift;
	endfunction

	assign reload = div_period(poly_cfg.div_code, poly_cfg.shift);

	always_comb begin
		feedback  = lfsr[0] ^ lfsr[1];
		lfsr_next = {feedback, lfsr[LW-1:1]};
		if (poly_cfg.short_mode) begin
			lfsr_next[`CH4_LFSR_SHORT_TAP] = feedback; // 7-bit loop
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			lfsr    <= '1;
			div_cnt <= '0;
		end else if (trigger) begin
			lfsr    <= '1;
			div_cnt <= reload;
		end else if (div_tick) begin
			if (div_cnt <= DIV_W'(1)) begin
				lfsr    <= lfsr_next; // shift on expiry
				div_cnt <= reload;
			end else begin
				div_cnt <= div_cnt - 1'b1;
			end
		end
	end

	assign noise_bit = ~lfsr[0];

	// all-zero is a dead state, the output would stick high
	a_lfsr_live: assert property (
		@(posedge clk) disable iff (reset)
		lfsr != '0
	) else $error("ch4_noise: lfsr reached all zero");

endmodule

// ==== src/ch4_envelope.sv ====
module ch4_envelope
	import ch4_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         env_tick,
	input  logic         trigger,
	input  ch4_env_cfg_t env_cfg,
	output logic [3:0]   volume
);

	logic [2:0] timer;
	logic [3:0] vol_next;
	logic       step_en;
	logic       timer_done;

	// saturating one-step move in the configured direction
	always_comb begin
		vol_next = volume;
		if (env_cfg.dir == ENV_UP) begin
			if (volume != 4'hf) begin
				vol_next = volume + 4'd1;
			end
		end else begin
			if (volume != 4'h0) begin
				vol_next = volume - 4'd1;
			end
		end
	end

	assign step_en    = env_tick && (env_cfg.period != 3'd0); // period 0 freezes
	assign timer_done = (timer <= 3'd1);

	always_ff @(posedge clk) begin
		if (reset) begin
			volume <= 4'd0;
			timer  <= 3'd0;
		end else if (trigger) begin
			volume <= env_cfg.init_vol;
			timer  <= env_cfg.period;
		end else if (step_en) begin
			if (timer_done) begin
				timer  <= env_cfg.period; // reload and step
				volume <= vol_next;
			end else begin
				timer <= timer - 3'd1;
			end
		end
	end

	// only a trigger may jump between the ends of the range
	a_no_wrap_up: assert property (
		@(posedge clk) disable iff (reset)
		(!trigger && (volume == 4'hf)) |=> (volume != 4'h0)
	) else $error("ch4_envelope: volume wrapped 15 to 0");

	a_no_wrap_down: assert property (
		@(posedge clk) disable iff (reset)
		(!trigger && (volume == 4'h0)) |=> (volume != 4'hf)
	) else $error("ch4_envelope: volume wrapped 0 to 15");

endmodule

// ==== src/ch4_length.sv ====
`include "ch4_settings.svh"

module ch4_length (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  len_tick,
	input  logic                  len_en,
	input  logic                  len_load,
	input  logic [`CH4_LEN_W-1:0] len_data,
	input  logic                  trigger,
	input  logic                  dac_on,
	output logic                  active
);

	localparam int CNT_W = `CH4_LEN_W + 1;
	localparam logic [CNT_W-1:0] FULL = CNT_W'(1 << `CH4_LEN_W); // 64

	logic [CNT_W-1:0] remaining; // ticks left before expiry
	logic             count_en;

	assign count_en = len_tick && len_en && (remaining != '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			remaining <= '0;
		end else if (len_load) begin
			remaining <= FULL - {1'b0, len_data};
		end else if (trigger) begin
			if (remaining == '0) begin
				remaining <= FULL; // expired counter restarts full
			end
		end else if (count_en) begin
			remaining <= remaining - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
		end else if (!dac_on) begin
			active <= 1'b0; // dac off kills the channel
		end else if (trigger) begin
			active <= 1'b1;
		end else if (count_en && (remaining == CNT_W'(1))) begin
			active <= 1'b0; // last tick, falls with the count
		end
	end

	// a running channel always has length ticks left
	a_active_left: assert property (
		@(posedge clk) disable iff (reset)
		active |-> (remaining != '0)
	) else $error("ch4_length: active with an expired counter");

endmodule

// ==== src/ch4_regs.sv ====
`include "ch4_settings.svh"

module ch4_regs
	import ch4_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	input  ch4_bus_t               bus,
	output logic [`CH4_DATA_W-1:0] rdata,
	output ch4_env_cfg_t           env_cfg,
	output ch4_poly_cfg_t          poly_cfg,
	output logic                   len_en,
	output logic                   len_load,
	output logic [`CH4_LEN_W-1:0]  len_data,
	output logic                   trigger,
	output logic                   dac_on
);

	localparam int DW = `CH4_DATA_W;

	logic wr_nr41;
	logic wr_nr42;
	logic wr_nr43;
	logic wr_nr44;

	assign wr_nr41 = bus.wr && (bus.addr == NR41);
	assign wr_nr42 = bus.wr && (bus.addr == NR42);
	assign wr_nr43 = bus.wr && (bus.addr == NR43);
	assign wr_nr44 = bus.wr && (bus.addr == NR44);

	// stored fields
	always_ff @(posedge clk) begin
		if (reset) begin
			env_cfg  <= '0;
			poly_cfg <= '0;
			len_en   <= 1'b0;
		end else begin
			if (wr_nr42) begin
				env_cfg <= ch4_env_cfg_t'(bus.wdata);
			end
			if (wr_nr43) begin
				poly_cfg <= ch4_poly_cfg_t'(bus.wdata);
			end
			if (wr_nr44) begin
				len_en <= bus.wdata[6]; // length enable level
			end
		end
	end

	// write pulses, high for the cycle after the write edge
	always_ff @(posedge clk) begin
		if (reset) begin
			len_load <= 1'b0;
			trigger  <= 1'b0;
		end else begin
			len_load <= wr_nr41;
			trigger  <= wr_nr44 && bus.wdata[7]; // bit 7 is never stored
		end
	end

	// length value rides along with len_load
	always_ff @(posedge clk) begin
		if (wr_nr41) begin
			len_data <= bus.wdata[`CH4_LEN_W-1:0];
		end
	end

	// volume or direction nonzero keeps the dac powered
	assign dac_on = (env_cfg.init_vol != 4'd0) || (env_cfg.dir == ENV_UP);

	// read-back, unreadable bits float high
	always_comb begin
		rdata = '1;
		if (bus.rd) begin
			case (bus.addr)
				NR41: rdata = '1; // write only
				NR42: rdata = DW'(env_cfg);
				NR43: rdata = DW'(poly_cfg);
				NR44: begin
					rdata    = '1;
					rdata[6] = len_en; // only readable bit
				end
				default: rdata = '1;
			endcase
		end
	end

	// the cpu side never issues a read and a write in the same cycle
	a_no_wr_rd: assert property (
		@(posedge clk) disable iff (reset)
		!(bus.wr && bus.rd)
	) else $error("ch4_regs: wr and rd high together");

endmodule

// ==== src/ch4_pkg.sv ====
`include "ch4_settings.svh"

package ch4_pkg;

	// register offsets from ff20
	typedef enum logic [1:0] {
		NR41 = 2'd0, // ff20 length load
		NR42 = 2'd1, // ff21 envelope
		NR43 = 2'd2, // ff22 polynomial counter
		NR44 = 2'd3  // ff23 control
	} ch4_reg_e;

	typedef enum logic {
		ENV_DOWN = 1'b0,
		ENV_UP   = 1'b1
	} env_dir_e;

	// one cpu access, strobes last a single cycle
	typedef struct packed {
		logic                   wr;
		logic                   rd;
		ch4_reg_e               addr;
		logic [`CH4_DATA_W-1:0] wdata;
	} ch4_bus_t;

	// ff21 in bit order 7..0
	typedef struct packed {
		logic [3:0] init_vol;
		env_dir_e   dir;
		logic [2:0] period;
	} ch4_env_cfg_t;

	// ff22 in bit order 7..0
	typedef struct packed {
		logic [3:0] shift;
		logic       short_mode;
		logic [2:0] div_code;
	} ch4_poly_cfg_t;

endpackage

// ==== src/ch4_settings.svh ====
`ifndef CH4_SETTINGS_SVH
`define CH4_SETTINGS_SVH

// cpu data bus width
`define CH4_DATA_W 8

// length load field, counter is one bit wider to hold 64
`define CH4_LEN_W 6

// full noise shift register width
`define CH4_LFSR_W 15

// extra feedback entry point in 7-bit mode
`define CH4_LFSR_SHORT_TAP 6

`endif
